//--- rtl/lsu_pkg.sv
package lsu_pkg;

  // data memory shape
  localparam int unsigned DMEM_WORDS = 256;                    // depth in 32-bit words
  localparam int unsigned DMEM_WAIT  = 2;                      // busy cycles per access
  localparam int unsigned DMEM_AW    = $clog2(DMEM_WORDS);     // word index width
  localparam int unsigned WAIT_W     = $clog2(DMEM_WAIT + 1);  // wait counter width

  typedef logic [31:0]        word_t;      // data or address word
  typedef logic [3:0]         byte_en_t;   // bit i = byte i, little-endian
  typedef logic [4:0]         reg_idx_t;   // destination register
  typedef logic [DMEM_AW-1:0] dmem_idx_t;  // word index into the memory array
  typedef logic [WAIT_W-1:0]  wait_cnt_t;  // memory wait-state count

  // access size and extension, stores only use LB/LH/LW
  typedef enum logic [2:0] {
    LB,
    LH,
    LW,
    LBU,
    LHU
  } load_t;

  // operation as it comes from the issuer
  typedef struct packed {
    logic     dren;        // load
    logic     dwen;        // store
    logic     wen;         // writes rd on completion
    reg_idx_t rd;
    load_t    load_type;
    word_t    base;        // rs1 value
    word_t    offset;      // sign-extended immediate
    word_t    store_data;  // rs2 value, low lanes meaningful
  } ls_req_t;

  // operation after address generation
  typedef struct packed {
    logic     dren;
    logic     dwen;
    logic     wen;
    reg_idx_t rd;
    load_t    load_type;
    word_t    store_data;
    word_t    address;     // effective byte address
    byte_en_t byte_en;     // lanes touched
    logic     mal_addr;    // size/alignment mismatch
  } ls_addr_t;

  // data bus request
  typedef struct packed {
    logic     ren;
    logic     wen;
    word_t    addr;
    byte_en_t byte_en;
    word_t    wdata;       // already replicated across lanes
  } dbus_req_t;

endpackage

//--- rtl/lsu_agu.sv
`timescale 1ns/1ns

// address generation, purely combinational
module lsu_agu (
  input  lsu_pkg::ls_req_t  req,
  output lsu_pkg::ls_addr_t addr_out
);

  lsu_pkg::word_t    eff_addr;
  lsu_pkg::byte_en_t lanes;
  logic              misaligned;
  logic              mem_op;

  assign eff_addr = req.base + req.offset;  // wraps at 2^32 like the core adder
  assign mem_op   = req.dren | req.dwen;

  // lane mask from size and low address bits
  always_comb begin
    lanes      = 4'b0000;
    misaligned = 1'b0;
    case (req.load_type)
      lsu_pkg::LB, lsu_pkg::LBU: begin
        lanes = 4'b0001 << eff_addr[1:0];  // any byte is fine
      end
      lsu_pkg::LH, lsu_pkg::LHU: begin
        lanes      = eff_addr[1] ? 4'b1100 : 4'b0011;
        misaligned = eff_addr[0];        // odd halfword
      end
      lsu_pkg::LW: begin
        lanes      = 4'b1111;
        misaligned = |eff_addr[1:0];     // word not on a 4-byte boundary
      end
      default: begin
        lanes      = 4'b0000;
        misaligned = 1'b0;
      end
    endcase
  end

  // carry the control fields straight through
  assign addr_out.dren       = req.dren;
  assign addr_out.dwen       = req.dwen;
  assign addr_out.wen        = req.wen;
  assign addr_out.rd         = req.rd;
  assign addr_out.load_type  = req.load_type;
  assign addr_out.store_data = req.store_data;
  assign addr_out.address    = eff_addr;
  assign addr_out.byte_en    = lanes;
  assign addr_out.mal_addr   = misaligned & mem_op;  // only a memory op can fault

endmodule

//--- rtl/lsu_mem_stage.sv
`timescale 1ns/1ns

// memory latch that holds one op while the data bus works on it
module lsu_mem_stage (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                ena,       // issuer has a valid op on addr_in
  input  logic                flush,
  input  logic                halt,
  input  lsu_pkg::ls_addr_t   addr_in,
  input  logic                bus_busy,  // memory still working
  output lsu_pkg::dbus_req_t  bus_req,
  output lsu_pkg::ls_addr_t   held,
  output logic                busy_ls,   // back-pressure to the issuer
  output logic                done       // one-cycle completion pulse
);

  lsu_pkg::ls_addr_t held_q;
  logic              access;   // stage holds a read or a write
  logic              stall;
  logic              stall_q;  // stall history for the done edge
  logic              kill;     // flush or halt

  assign kill   = flush | halt;
  assign access = held_q.dren | held_q.dwen;
  assign stall  = bus_busy & access;

  // priority is kill, then a new op, then the completion clear
  // a new op presented in the done cycle replaces the finished one directly
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      held_q <= '0;
    end else if (kill) begin
      held_q <= '0;                   // whole stage dropped
    end else if (!stall && ena) begin
      held_q <= addr_in;
    end else if (!stall) begin
      // finished, misaligned or idle op is dropped so no access repeats
      held_q <= '0;
    end
  end

  // registered stall whose falling edge gives done
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      stall_q <= 1'b0;
    end else if (kill) begin
      stall_q <= 1'b0;                // cancelled op gives no done
    end else begin
      stall_q <= stall;
    end
  end

  assign done    = stall_q & ~stall;
  assign busy_ls = stall;             // high from the take edge until done
  assign held    = held_q;

  // a misaligned op never gets a bus strobe
  assign bus_req.ren     = held_q.dren & ~held_q.mal_addr;
  assign bus_req.wen     = held_q.dwen & ~held_q.mal_addr;
  assign bus_req.addr    = held_q.address;
  assign bus_req.byte_en = held_q.byte_en;

  // replicate store data so every enabled lane sees it
  always_comb begin
    bus_req.wdata = '0;
    case (held_q.load_type)         // store size reuses the load encoding
      lsu_pkg::LB, lsu_pkg::LBU: bus_req.wdata = {4{held_q.store_data[7:0]}};
      lsu_pkg::LH, lsu_pkg::LHU: bus_req.wdata = {2{held_q.store_data[15:0]}};
      lsu_pkg::LW:               bus_req.wdata = held_q.store_data;
      default:                   bus_req.wdata = '0;
    endcase
  end

  // a single op is either a load or a store on the bus
  a_one_strobe : assert property (
    @(posedge CLK) disable iff (!nRST)
    !(bus_req.ren && bus_req.wen)
  ) else $error("bus ren and wen high together");

  // done exactly when the memory lets go of a live access
  a_done_not_busy : assert property (
    @(posedge CLK) disable iff (!nRST)
    done == ($fell(bus_busy) && (bus_req.ren || bus_req.wen))
  ) else $error("done does not match the end of the bus access");

  // misaligned requests never keep the memory busy
  a_mal_off_bus : assert property (
    @(posedge CLK) disable iff (!nRST)
    held_q.mal_addr |-> !bus_busy
  ) else $error("misaligned request reached the bus");

endmodule

//--- rtl/lsu_load_extend.sv
`timescale 1ns/1ns

// picks the addressed lane out of the bus word and extends it
module lsu_load_extend (
  input  lsu_pkg::word_t    rdata,
  input  lsu_pkg::load_t    load_type,
  input  lsu_pkg::byte_en_t byte_en,
  output lsu_pkg::word_t    ext
);

  logic [7:0]  lane_b;  // selected byte
  logic [15:0] lane_h;  // selected halfword

  // lane select, little-endian only
  always_comb begin
    case (byte_en)
      4'b0010: lane_b = rdata[15:8];
      4'b0100: lane_b = rdata[23:16];
      4'b1000: lane_b = rdata[31:24];
      default: lane_b = rdata[7:0];   // lane 0
    endcase
    lane_h = byte_en[2] ? rdata[31:16] : rdata[15:0];  // upper half if lanes 2/3
  end

  // sign for LB/LH, zero for LBU/LHU
  always_comb begin
    case (load_type)
      lsu_pkg::LB: begin
        ext = {{24{lane_b[7]}}, lane_b};
      end
      lsu_pkg::LH: begin
        ext = {{16{lane_h[15]}}, lane_h};
      end
      lsu_pkg::LBU: begin
        ext = {24'h0, lane_b};
      end
      lsu_pkg::LHU: begin
        ext = {16'h0, lane_h};
      end
      lsu_pkg::LW: begin
        ext = rdata;                  // whole word untouched
      end
      default: begin
        ext = rdata;
      end
    endcase
  end

endmodule

//--- rtl/lsu_dmem.sv
`timescale 1ns/1ns

// word-wide data memory, fixed wait states per access
module lsu_dmem (
  input  logic               CLK,
  input  logic               nRST,
  input  lsu_pkg::dbus_req_t bus_req,
  output logic               busy,
  output lsu_pkg::word_t     rdata
);

  lsu_pkg::word_t    mem [lsu_pkg::DMEM_WORDS];
  lsu_pkg::wait_cnt_t cnt_q;     // cycles spent on the current request
  lsu_pkg::dmem_idx_t idx;
  logic               active;    // request on the bus
  logic               last;      // wait states used up

  assign active = bus_req.ren | bus_req.wen;
  assign idx    = bus_req.addr[lsu_pkg::DMEM_AW+1:2];  // byte address to word index
  assign last   = cnt_q == lsu_pkg::wait_cnt_t'(lsu_pkg::DMEM_WAIT);
  assign busy   = active & ~last;

  // wait counter restarts for every request
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt_q <= '0;
    end else if (!active || last) begin
      cnt_q <= '0;                 // idle, dropped request or access finished
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // lane writes land at the end of the wait
  always_ff @(posedge CLK) begin
    if (bus_req.wen && last) begin
      for (int i = 0; i < 4; i++) begin
        if (bus_req.byte_en[i]) begin
          mem[idx][i*8 +: 8] <= bus_req.wdata[i*8 +: 8];
        end
      end
    end
  end

  // read word shown only in the cycle the access ends
  assign rdata = (bus_req.ren && last) ? mem[idx] : '0;

  // effective address from the agu must land inside the array
  a_addr_in_range : assert property (
    @(posedge CLK) disable iff (!nRST)
    active |-> (bus_req.addr[31:2] < 30'(lsu_pkg::DMEM_WORDS))
  ) else $error("dmem address out of range %h", bus_req.addr);

endmodule

//--- rtl/lsu_top.sv
`timescale 1ns/1ns

// load/store unit with its own data memory
module lsu_top (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              ena,
  input  logic              flush,
  input  logic              halt,
  input  lsu_pkg::ls_req_t  req,
  output logic              busy_ls,
  output logic              done,
  output logic              wen_out,
  output lsu_pkg::reg_idx_t rd_out,
  output lsu_pkg::word_t    wdata,
  output logic              mal_addr
);

  lsu_pkg::ls_addr_t  agu_addr;  // agu to latch
  lsu_pkg::ls_addr_t  held;      // latch contents
  lsu_pkg::dbus_req_t bus_req;
  lsu_pkg::word_t     bus_rdata;
  logic               bus_busy;

  lsu_agu agu_i (
    .req      (req),
    .addr_out (agu_addr)
  );

  lsu_mem_stage mem_stage_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .ena      (ena),
    .flush    (flush),
    .halt     (halt),
    .addr_in  (agu_addr),
    .bus_busy (bus_busy),
    .bus_req  (bus_req),
    .held     (held),
    .busy_ls  (busy_ls),
    .done     (done)
  );

  lsu_load_extend load_ext_i (
    .rdata     (bus_rdata),
    .load_type (held.load_type),
    .byte_en   (held.byte_en),
    .ext       (wdata)
  );

  lsu_dmem dmem_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .bus_req (bus_req),
    .busy    (bus_busy),
    .rdata   (bus_rdata)
  );

  // writeback fields, qualified by done outside
  assign wen_out  = held.wen;
  assign rd_out   = held.rd;
  assign mal_addr = held.mal_addr;

endmodule

//--- tests/lsu_tb.sv
`timescale 1ns/1ns

module lsu_tb;

  // kind of row in the stimulus table
  typedef enum logic [1:0] {
    K_LOAD,
    K_STORE,
    K_FLUSH,  // store cancelled by flush
    K_HALT    // store cancelled by halt
  } op_kind_t;

  typedef struct packed {
    op_kind_t       kind;
    lsu_pkg::load_t load_type;
    lsu_pkg::word_t base;
    lsu_pkg::word_t offset;
    lsu_pkg::word_t sdata;
    lsu_pkg::word_t exp;    // expected wdata of a load
    logic           mal;    // expected misaligned
    logic           chain;  // presented while the previous row is still busy
  } row_t;

  logic               CLK;
  logic               nRST;
  logic               ena;
  logic               flush;
  logic               halt;
  lsu_pkg::ls_req_t   req;
  logic               busy_ls;
  logic               done;
  logic               wen_out;
  lsu_pkg::reg_idx_t  rd_out;
  lsu_pkg::word_t     wdata;
  logic               mal_addr;

  row_t rows[$];
  int   errors;
  int   done_count;   // every done pulse seen
  int   exp_done;     // aligned, uncancelled rows
  logic table_ready;

  lsu_top dut_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .ena      (ena),
    .flush    (flush),
    .halt     (halt),
    .req      (req),
    .busy_ls  (busy_ls),
    .done     (done),
    .wen_out  (wen_out),
    .rd_out   (rd_out),
    .wdata    (wdata),
    .mal_addr (mal_addr)
  );

  always #4 CLK = ~CLK;  // 8 ns period

  always @(negedge CLK) begin
    if (nRST && done) done_count++;  // independent pulse count
  end

  // little-endian lane write of a store into an old word
  function automatic lsu_pkg::word_t lane_merge(lsu_pkg::word_t old, lsu_pkg::word_t data,
                                                lsu_pkg::load_t size, logic [1:0] lane);
    lsu_pkg::word_t w;
    w = old;
    case (size)
      lsu_pkg::LB: w[lane*8 +: 8]  = data[7:0];
      lsu_pkg::LH: w[lane*8 +: 16] = data[15:0];  // lane 0 or 2
      default:     w = data;
    endcase
    return w;
  endfunction

  function automatic row_t mk_row(op_kind_t k, lsu_pkg::load_t t, lsu_pkg::word_t base,
                                  lsu_pkg::word_t off, lsu_pkg::word_t sd,
                                  lsu_pkg::word_t exp, logic mal, logic chain);
    row_t r;
    r.kind      = k;
    r.load_type = t;
    r.base      = base;
    r.offset    = off;
    r.sdata     = sd;
    r.exp       = exp;
    r.mal       = mal;
    r.chain     = chain;
    return r;
  endfunction

  task automatic build_table();
    lsu_pkg::word_t w104;  // expected contents of word 0x104
    w104 = 32'h11223344;
    rows.push_back(mk_row(K_STORE, lsu_pkg::LW, 32'h100, 0, 32'hDEADBEEF, 0, 0, 0));
    rows.push_back(mk_row(K_LOAD,  lsu_pkg::LW, 32'h100, 0, 0, 32'hDEADBEEF, 0, 0));
    rows.push_back(mk_row(K_STORE, lsu_pkg::LW, 32'h104, 0, w104, 0, 0, 0));
    w104 = lane_merge(w104, 32'hA5, lsu_pkg::LB, 2'd1);
    rows.push_back(mk_row(K_STORE, lsu_pkg::LB, 32'h104, 1, 32'hA5, 0, 0, 0));
    w104 = lane_merge(w104, 32'hBEEF, lsu_pkg::LH, 2'd2);
    rows.push_back(mk_row(K_STORE, lsu_pkg::LH, 32'h104, 2, 32'hBEEF, 0, 0, 1));
    w104 = lane_merge(w104, 32'h7C, lsu_pkg::LB, 2'd3);
    rows.push_back(mk_row(K_STORE, lsu_pkg::LB, 32'h108, 32'hFFFFFFFF, 32'h7C, 0, 0, 0));
    rows.push_back(mk_row(K_LOAD,  lsu_pkg::LW, 32'h104, 0, 0, w104, 0, 1));  // 7CEFA544
    w104 = lane_merge(w104, 32'h12348001, lsu_pkg::LH, 2'd0);
    rows.push_back(mk_row(K_STORE, lsu_pkg::LH, 32'h104, 0, 32'h12348001, 0, 0, 0));
    rows.push_back(mk_row(K_LOAD,  lsu_pkg::LW, 32'h104, 0, 0, w104, 0, 0));  // 7CEF8001
    // extension of lanes with the top bit set
    rows.push_back(mk_row(K_LOAD, lsu_pkg::LB,  32'h104, 1, 0, 32'hFFFFFF80, 0, 0));
    rows.push_back(mk_row(K_LOAD, lsu_pkg::LBU, 32'h104, 1, 0, 32'h00000080, 0, 1));
    rows.push_back(mk_row(K_LOAD, lsu_pkg::LH,  32'h104, 0, 0, 32'hFFFF8001, 0, 0));
    rows.push_back(mk_row(K_LOAD, lsu_pkg::LHU, 32'h104, 0, 0, 32'h00008001, 0, 0));
    rows.push_back(mk_row(K_LOAD, lsu_pkg::LH,  32'h104, 2, 0, 32'h00007CEF, 0, 0));
    rows.push_back(mk_row(K_LOAD, lsu_pkg::LBU, 32'h104, 3, 0, 32'h0000007C, 0, 1));
    rows.push_back(mk_row(K_LOAD, lsu_pkg::LB,  32'h100, 3, 0, 32'hFFFFFFDE, 0, 0));
    rows.push_back(mk_row(K_LOAD, lsu_pkg::LHU, 32'h100, 2, 0, 32'h0000DEAD, 0, 0));
    rows.push_back(mk_row(K_LOAD, lsu_pkg::LH,  32'h100, 2, 0, 32'hFFFFDEAD, 0, 0));
    // byte stores and loads on lanes 0 and 2
    w104 = lane_merge(w104, 32'hC3, lsu_pkg::LB, 2'd0);
    rows.push_back(mk_row(K_STORE, lsu_pkg::LB,  32'h104, 0, 32'hC3, 0, 0, 0));
    w104 = lane_merge(w104, 32'h96, lsu_pkg::LB, 2'd2);
    rows.push_back(mk_row(K_STORE, lsu_pkg::LB,  32'h106, 0, 32'h96, 0, 0, 1));
    rows.push_back(mk_row(K_LOAD,  lsu_pkg::LW,  32'h104, 0, 0, w104, 0, 0));  // 7C9680C3
    rows.push_back(mk_row(K_LOAD,  lsu_pkg::LB,  32'h104, 2, 0, 32'hFFFFFF96, 0, 0));
    rows.push_back(mk_row(K_LOAD,  lsu_pkg::LBU, 32'h104, 0, 0, 32'h000000C3, 0, 0));
    // misaligned ops stay off the bus
    rows.push_back(mk_row(K_STORE, lsu_pkg::LW,  32'h100, 1, 32'h55555555, 0, 1, 0));
    rows.push_back(mk_row(K_STORE, lsu_pkg::LH,  32'h100, 3, 32'h5555, 0, 1, 0));
    rows.push_back(mk_row(K_LOAD,  lsu_pkg::LW,  32'h102, 0, 0, 0, 1, 0));
    rows.push_back(mk_row(K_LOAD,  lsu_pkg::LHU, 32'h101, 0, 0, 0, 1, 0));
    rows.push_back(mk_row(K_LOAD,  lsu_pkg::LW,  32'h100, 0, 0, 32'hDEADBEEF, 0, 0));
    // cancelled stores leave memory as it was
    rows.push_back(mk_row(K_FLUSH, lsu_pkg::LW, 32'h100, 0, 32'h0BADF00D, 0, 0, 0));
    rows.push_back(mk_row(K_HALT,  lsu_pkg::LB, 32'h104, 0, 32'hFF, 0, 0, 0));
    rows.push_back(mk_row(K_LOAD,  lsu_pkg::LW, 32'h100, 0, 0, 32'hDEADBEEF, 0, 0));
    rows.push_back(mk_row(K_LOAD,  lsu_pkg::LW, 32'h104, 0, 0, w104, 0, 1));
    exp_done = 0;
    foreach (rows[i]) begin
      if ((rows[i].kind == K_LOAD || rows[i].kind == K_STORE) && !rows[i].mal) exp_done++;
    end
  endtask

  task automatic drive_row(input row_t r, input int idx);
    req            = '0;
    req.dren       = (r.kind == K_LOAD);
    req.dwen       = (r.kind != K_LOAD);  // flush/halt rows are stores
    req.wen        = (r.kind == K_LOAD);
    req.rd         = 5'(idx);
    req.load_type  = r.load_type;
    req.base       = r.base;
    req.offset     = r.offset;
    req.store_data = r.sdata;
    ena            = 1'b1;
  endtask

  // returns at the edge that takes the op with busy_ls sampled mid-cycle
  task automatic wait_take(input int idx);
    logic b;
    int   n;
    n = 0;
    b = busy_ls;
    @(posedge CLK);
    while (b && n < 16) begin
      #1;
      b = busy_ls;
      @(posedge CLK);
      n++;
    end
    if (b) begin
      $display("row %0d was never taken, busy_ls stuck high", idx);
      errors++;
    end
  endtask

  task automatic wait_done(input row_t r, input int idx);
    int n;
    bit seen;
    seen = 0;
    n = 0;
    while (!seen && n < lsu_pkg::DMEM_WAIT + 6) begin
      @(negedge CLK);
      n++;
      if (done) begin
        seen = 1;
        if (n != lsu_pkg::DMEM_WAIT + 1) begin
          $display("ERR row %0d done cycle got %h exp %h", idx, n, lsu_pkg::DMEM_WAIT + 1);
          errors++;
        end
        if (r.kind == K_LOAD && wdata !== r.exp) begin
          $display("ERR row %0d wdata got %h exp %h", idx, wdata, r.exp);
          errors++;
        end
        if (wen_out !== (r.kind == K_LOAD)) begin
          $display("ERR row %0d wen_out got %h exp %h", idx, wen_out, r.kind == K_LOAD);
          errors++;
        end
        if (rd_out !== 5'(idx)) begin
          $display("ERR row %0d rd_out got %h exp %h", idx, rd_out, 5'(idx));
          errors++;
        end
        if (mal_addr !== 1'b0) begin
          $display("ERR row %0d mal_addr got %h exp 0", idx, mal_addr);
          errors++;
        end
      end else if (busy_ls !== 1'b1) begin  // back-pressure must hold until done
        $display("ERR row %0d busy_ls got %h exp 1", idx, busy_ls);
        errors++;
      end
    end
    if (!seen) begin
      $display("row %0d finished with no done pulse", idx);
      errors++;
    end
  endtask

  task automatic check_quiet(input int idx, input int cycles);
    repeat (cycles) begin
      @(negedge CLK);
      if (done) begin
        $display("row %0d gave a done pulse it should not have", idx);
        errors++;
      end
      if (mal_addr !== 1'b0) begin
        $display("ERR row %0d mal_addr got %h exp 0", idx, mal_addr);
        errors++;
      end
    end
  endtask

  task automatic check_mal(input int idx);
    @(negedge CLK);
    if (mal_addr !== 1'b1) begin
      $display("ERR row %0d mal_addr got %h exp 1", idx, mal_addr);
      errors++;
    end
    if (dut_i.bus_req.ren || dut_i.bus_req.wen) begin
      $display("row %0d put a misaligned access on the bus", idx);
      errors++;
    end
    check_quiet(idx, lsu_pkg::DMEM_WAIT + 1);  // cleared with no done
  endtask

  initial begin
    int   gap;
    logic presented;
    row_t r;
    CLK         = 1'b0;
    nRST        = 1'b0;
    ena         = 1'b0;
    flush       = 1'b0;
    halt        = 1'b0;
    req         = '0;
    errors      = 0;
    done_count  = 0;
    table_ready = 1'b0;
    presented   = 1'b0;
    void'($urandom(32'h4ab2bd9a));
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge CLK);
    #1;
    nRST = 1'b1;
    if (busy_ls || done || wen_out || mal_addr || dut_i.bus_req.ren || dut_i.bus_req.wen) begin
      $display("outputs or bus strobes not low after reset");
      errors++;
    end

    foreach (rows[i]) begin
      r = rows[i];
      if (!presented) begin
        gap = int'($urandom % 3);  // idle cycles between ops
        repeat (gap) @(posedge CLK);
        @(posedge CLK);
        #1;
        drive_row(r, i);
      end
      presented = 1'b0;
      wait_take(i);
      #1;
      if (i + 1 < rows.size() && rows[i+1].chain) begin
        drive_row(rows[i+1], i + 1);  // held off by busy_ls until this one is done
        presented = 1'b1;
      end else begin
        ena = 1'b0;
        req = '0;
      end
      if (r.kind == K_FLUSH || r.kind == K_HALT) begin
        @(posedge CLK);
        #1;
        flush = (r.kind == K_FLUSH);
        halt  = (r.kind == K_HALT);
        @(posedge CLK);
        #1;
        flush = 1'b0;
        halt  = 1'b0;
        check_quiet(i, lsu_pkg::DMEM_WAIT + 1);
      end else if (r.mal) begin
        check_mal(i);
      end else begin
        wait_done(r, i);
      end
    end

    repeat (4) @(posedge CLK);
    if (done_count != exp_done) begin
      $display("ERR done_count got %h exp %h", done_count, exp_done);
      errors++;
    end
    $display("rows=%0d errors=%0d done_pulses=%0d", rows.size(), errors, done_count);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog budget per row plus the reset time
  initial begin
    int wd_cycles;
    wait (table_ready);
    wd_cycles = rows.size() * (lsu_pkg::DMEM_WAIT + 8) + 8;
    repeat (wd_cycles) @(posedge CLK);
    $display("watchdog expired after %0d cycles, run did not finish", wd_cycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- filelist.f
rtl/lsu_pkg.sv
rtl/lsu_agu.sv
rtl/lsu_mem_stage.sv
rtl/lsu_load_extend.sv
rtl/lsu_dmem.sv
rtl/lsu_top.sv
tests/lsu_tb.sv

//--- Makefile
TOP = lsu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ]; then exit 1; fi
	@if grep -q "TESTS FAILED" sim.log; then \
		echo "simulation failed, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
